// File: robCore.f
+incdir+tests
hw/robPkg.sv
hw/renameStage.sv
hw/reorderBuffer.sv
hw/retireRat.sv
hw/robCore.sv
tests/robCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the robCore testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=$BUILD_DIR/sim.log

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module robCoreTb -Mdir "$BUILD_DIR" -f robCore.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VrobCoreTb" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG_FILE"; then
    echo "robCore run: pass"
    exit 0
else
    echo "robCore run: fail"
    exit 1
fi

// File: tests/robCoreModel.svh
// ----------------------------------------------------------
// robCore reference model
// rename, free list, ROB order and committed map
// ----------------------------------------------------------
`ifndef ROB_CORE_MODEL_SVH
`define ROB_CORE_MODEL_SVH

typedef struct packed {
    logic [robPkg::TAG_W-1:0]   tag;
    logic [robPkg::PC_W-1:0]    pc;
    logic [robPkg::ARCH_W-1:0]  arch;
    logic [robPkg::PHYS_W-1:0]  phys;
    logic [robPkg::PHYS_W-1:0]  oldPhys;
    logic                       hasDst;
    logic                       done;
} robEntry;

logic [robPkg::PHYS_W-1:0]  mSpecMap   [robPkg::ARCH_REGS];
logic [robPkg::PHYS_W-1:0]  mCommitMap [robPkg::ARCH_REGS];
logic [robPkg::PHYS_W-1:0]  mFreeQ     [$];
robEntry                    robQ       [$];     // ROB contents, oldest first
robEntry                    pend;               // entry held in the rename register
bit                         pendValid;
robEntry                    expRet;             // fields shown on the retire outputs
bit                         expRetValid;
bit                         mFreeValid;
logic [robPkg::PHYS_W-1:0]  mFreePhys;
logic [robPkg::TAG_W-1:0]   mNextTag;

function automatic void modelReset();
    for (int i = 0; i < robPkg::ARCH_REGS; i++) begin
        mSpecMap[i]   = robPkg::PHYS_W'(i);
        mCommitMap[i] = robPkg::PHYS_W'(i);
    end
    mFreeQ.delete();
    for (int i = 0; i < robPkg::FREE_REGS; i++) begin
        mFreeQ.push_back(robPkg::PHYS_W'(robPkg::ARCH_REGS + i));   // 16 up to 31
    end
    robQ.delete();
    pend        = '0;
    pendValid   = 1'b0;
    expRet      = '0;
    expRetValid = 1'b0;
    mFreeValid  = 1'b0;
    mFreePhys   = '0;
    mNextTag    = '0;
endfunction

// the pending entry already counts as a taken ROB slot
function automatic bit modelReady();
    return mFreeQ.size() != 0 && robQ.size() + int'(pendValid) < robPkg::ROB_SIZE;
endfunction

function automatic int undoneCount();
    int n = 0;
    foreach (robQ[i]) begin
        if (!robQ[i].done) begin
            n++;
        end
    end
    return n;
endfunction

function automatic logic [robPkg::TAG_W-1:0] undoneTag(input int k);
    int seen = 0;
    foreach (robQ[i]) begin
        if (!robQ[i].done) begin
            if (seen == k) begin
                return robQ[i].tag;
            end
            seen++;
        end
    end
    return '0;
endfunction

// one rising edge of the whole pipeline
function automatic void modelStep(input bit offer, input logic [robPkg::PC_W-1:0] pc,
        input logic [robPkg::ARCH_W-1:0] arch, input bit dst,
        input bit comp, input logic [robPkg::TAG_W-1:0] compTag);
    robEntry e;
    robEntry hit;
    bit accept;
    bit retire;
    bit ratWrite;
    accept   = offer && modelReady();
    retire   = robQ.size() != 0 && robQ[0].done;    // done bits before this edge
    ratWrite = expRetValid && expRet.hasDst;
    e        = '0;
    e.tag    = mNextTag;
    e.pc     = pc;
    e.arch   = arch;
    e.hasDst = dst;
    if (accept && dst) begin
        e.phys         = mFreeQ.pop_front();
        e.oldPhys      = mSpecMap[arch];
        mSpecMap[arch] = e.phys;
    end
    if (mFreeValid) begin
        mFreeQ.push_back(mFreePhys);
    end
    if (ratWrite) begin
        mCommitMap[expRet.arch] = expRet.phys;
    end
    mFreeValid = ratWrite;
    mFreePhys  = expRet.oldPhys;
    foreach (robQ[i]) begin
        if (comp && robQ[i].tag == compTag) begin
            hit      = robQ[i];
            hit.done = 1'b1;
            robQ[i]  = hit;
        end
    end
    expRetValid = retire;
    if (retire) begin
        expRet = robQ.pop_front();
    end
    if (pendValid) begin
        robQ.push_back(pend);
    end
    pendValid = accept;
    pend      = e;
    if (accept) begin
        mNextTag++;
    end
endfunction

`endif

// File: tests/robCoreTb.sv
// ----------------------------------------------------------
// robCore testbench
// random dispatch and completion checked against a model
// ----------------------------------------------------------
`default_nettype none

module robCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DISPATCHES   = 600;
    localparam int RESET_CYCLES = 16;
    localparam int STALL_CYCLES = 40;
    localparam int CYCLE_LIMIT  = DISPATCHES * 8 + RESET_CYCLES;

    logic                       CLK, RESET;
    logic                       dispatchValid, hasDst, completeValid;
    logic [robPkg::PC_W-1:0]    dispatchPc;
    logic [robPkg::ARCH_W-1:0]  dispatchArch, queryArch;
    logic [robPkg::TAG_W-1:0]   completeTag, dispatchTag;
    logic                       dispatchReady, retireValid, retireHasDst;
    logic [robPkg::PC_W-1:0]    retirePc;
    logic [robPkg::ARCH_W-1:0]  retireArch;
    logic [robPkg::PHYS_W-1:0]  dispatchPhys, retirePhys, retireOldPhys, queryPhys;

    int             errors;
    int             accepted;
    int             cycles;
    bit             sawFull;
    logic [31:0]    seed;

    `include "robCoreModel.svh"

    robCore uut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] randomWord();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // ------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------
    task automatic checkTag(input string name, input logic [robPkg::TAG_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkPhys(input string name, input logic [robPkg::PHYS_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkArch(input string name, input logic [robPkg::ARCH_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkPc(input string name, input logic [robPkg::PC_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------
    // one cycle of stimulus, checks and model update
    // ------------------------------------------------------
    task automatic runCycle(input int offerLevel, input bit completeOn);
        logic [31:0] r;
        bit offer;
        bit comp;
        bit ready;
        int open;
        @(negedge CLK);
        checkFlag("retireValid", retireValid, expRetValid);   // registered at the last edge
        if (expRetValid) begin
            checkPc("retirePc", retirePc, expRet.pc);
            checkArch("retireArch", retireArch, expRet.arch);
            checkPhys("retirePhys", retirePhys, expRet.phys);
            checkPhys("retireOldPhys", retireOldPhys, expRet.oldPhys);
            checkFlag("retireHasDst", retireHasDst, expRet.hasDst);
        end
        r     = randomWord();
        open  = undoneCount();
        offer = int'(r[31:28]) < offerLevel;    // level out of 16
        comp  = completeOn && open != 0 && r[21:20] != 2'b00;
        dispatchValid = offer;
        dispatchPc    = randomWord();
        dispatchArch  = r[25:22];
        hasDst        = r[27:26] != 2'b00;      // about 3/4 write a register
        completeValid = comp;
        completeTag   = '0;
        if (comp) begin
            completeTag = undoneTag(int'(r[15:0]) % open);
        end
        queryArch = r[19:16];
        #1;
        ready = modelReady();
        checkFlag("dispatchReady", dispatchReady, ready);
        checkPhys("queryPhys", queryPhys, mCommitMap[queryArch]);
        if (offer && ready) begin
            checkTag("dispatchTag", dispatchTag, mNextTag);
            checkPhys("dispatchPhys", dispatchPhys, hasDst ? mFreeQ[0] : '0);
            accepted++;
        end
        // DUT holds dispatch back while the ROB is full
        if (!dispatchReady && robQ.size() + int'(pendValid) >= robPkg::ROB_SIZE) begin
            sawFull = 1'b1;
        end
        modelStep(offer, dispatchPc, dispatchArch, hasDst, comp, completeTag);
    endtask

    initial begin
        seed          = 32'he5a7_d4f6;
        errors        = 0;
        accepted      = 0;
        sawFull       = 1'b0;
        RESET         = 1'b0;
        dispatchValid = 1'b0;
        dispatchPc    = '0;
        dispatchArch  = '0;
        hasDst        = 1'b0;
        completeValid = 1'b0;
        completeTag   = '0;
        queryArch     = '0;
        modelReset();
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b1;

        // idle sweep of the committed map right after reset
        for (int i = 0; i < robPkg::ARCH_REGS; i++) begin
            @(negedge CLK);
            queryArch = robPkg::ARCH_W'(i);
            #1;
            checkFlag("dispatchReady", dispatchReady, 1'b1);
            checkFlag("retireValid", retireValid, 1'b0);
            checkPhys("queryPhys", queryPhys, robPkg::PHYS_W'(i));
        end

        while (accepted < DISPATCHES / 2) begin
            runCycle(10, 1'b1);
        end
        // completions stop, so the ROB has to fill and block dispatch
        sawFull = 1'b0;
        repeat (STALL_CYCLES) runCycle(16, 1'b0);
        if (!sawFull) begin
            errors++;
            $display("completions were stopped but the ROB never filled up");
        end
        while (accepted < DISPATCHES) begin
            runCycle(10, 1'b1);
        end
        // drain until the last retire and free return have landed
        while (robQ.size() != 0 || pendValid || expRetValid || mFreeValid) begin
            runCycle(0, 1'b1);
        end
        repeat (32) runCycle(0, 1'b0);

        $display("checks done: %0d errors, %0d dispatches accepted", errors, accepted);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/robCore.sv
// ----------------------------------------------------------
// robCore
// rename, reorder buffer and retirement RAT in one pipeline
// ----------------------------------------------------------
`default_nettype none

module robCore (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         dispatchValid,
    input  wire  [robPkg::PC_W-1:0]     dispatchPc,
    input  wire  [robPkg::ARCH_W-1:0]   dispatchArch,
    input  wire                         hasDst,
    input  wire                         completeValid,
    input  wire  [robPkg::TAG_W-1:0]    completeTag,
    input  wire  [robPkg::ARCH_W-1:0]   queryArch,
    output logic                        dispatchReady,
    output logic [robPkg::TAG_W-1:0]    dispatchTag,
    output logic [robPkg::PHYS_W-1:0]   dispatchPhys,
    output logic                        retireValid,
    output logic [robPkg::PC_W-1:0]     retirePc,
    output logic [robPkg::ARCH_W-1:0]   retireArch,
    output logic [robPkg::PHYS_W-1:0]   retirePhys,
    output logic [robPkg::PHYS_W-1:0]   retireOldPhys,
    output logic                        retireHasDst,
    output logic [robPkg::PHYS_W-1:0]   queryPhys
);

    // rename to ROB
    logic                       allocValid;
    logic [robPkg::PC_W-1:0]    allocPc;
    logic [robPkg::ARCH_W-1:0]  allocArch;
    logic [robPkg::PHYS_W-1:0]  allocPhys;
    logic [robPkg::PHYS_W-1:0]  allocOldPhys;
    logic                       allocHasDst;

    // ROB back to rename
    logic                       robFull;
    logic [robPkg::TAG_W-1:0]   nextTag;

    // RAT back to rename
    logic                       freeValid;
    logic [robPkg::PHYS_W-1:0]  freePhys;

    renameStage rename (.*);

    reorderBuffer rob (.*);

    retireRat rat (.*);

endmodule

`default_nettype wire

// File: hw/retireRat.sv
// ----------------------------------------------------------
// retirement RAT
// committed map, register return and committed map lookup
// ----------------------------------------------------------
`default_nettype none

module retireRat (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         retireValid,
    input  wire  [robPkg::ARCH_W-1:0]   retireArch,
    input  wire  [robPkg::PHYS_W-1:0]   retirePhys,
    input  wire  [robPkg::PHYS_W-1:0]   retireOldPhys,
    input  wire                         retireHasDst,
    input  wire  [robPkg::ARCH_W-1:0]   queryArch,
    output logic                        freeValid,
    output logic [robPkg::PHYS_W-1:0]   freePhys,
    output logic [robPkg::PHYS_W-1:0]   queryPhys
);

    logic [robPkg::PHYS_W-1:0]  commitMap [robPkg::ARCH_REGS];
    logic                       commitWrite;

    assign commitWrite = retireValid && retireHasDst;
    assign queryPhys   = commitMap[queryArch];      // plain table read

    // ------------------------------------------------------
    // committed table, identity after reset
    // ------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < robPkg::ARCH_REGS; i++) begin
                commitMap[i] <= robPkg::PHYS_W'(i);
            end
        end else if (commitWrite) begin
            commitMap[retireArch] <= retirePhys;
        end
    end

    // ------------------------------------------------------
    // return of the replaced register
    // ------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            freeValid <= 1'b0;
        end else begin
            freeValid <= commitWrite;
        end
    end

    always_ff @(posedge CLK) begin
        if (commitWrite) begin
            freePhys <= retireOldPhys;
        end
    end

    // in-order retire means the old mapping seen at rename is still committed
    oldPhysMatch: assert property (@(posedge CLK) disable iff (!RESET)
        commitWrite |-> commitMap[retireArch] == retireOldPhys);

endmodule

`default_nettype wire

// File: hw/reorderBuffer.sv
// ----------------------------------------------------------
// reorder buffer
// in-order queue, completion marking, single registered retire
// ----------------------------------------------------------
`default_nettype none

module reorderBuffer (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         allocValid,
    input  wire  [robPkg::PC_W-1:0]     allocPc,
    input  wire  [robPkg::ARCH_W-1:0]   allocArch,
    input  wire  [robPkg::PHYS_W-1:0]   allocPhys,
    input  wire  [robPkg::PHYS_W-1:0]   allocOldPhys,
    input  wire                         allocHasDst,
    input  wire                         completeValid,
    input  wire  [robPkg::TAG_W-1:0]    completeTag,
    output logic                        robFull,
    output logic [robPkg::TAG_W-1:0]    nextTag,
    output logic                        retireValid,
    output logic [robPkg::PC_W-1:0]     retirePc,
    output logic [robPkg::ARCH_W-1:0]   retireArch,
    output logic [robPkg::PHYS_W-1:0]   retirePhys,
    output logic [robPkg::PHYS_W-1:0]   retireOldPhys,
    output logic                        retireHasDst
);

    // entry payload
    logic [robPkg::PC_W-1:0]    entPc      [robPkg::ROB_SIZE];
    logic [robPkg::ARCH_W-1:0]  entArch    [robPkg::ROB_SIZE];
    logic [robPkg::PHYS_W-1:0]  entPhys    [robPkg::ROB_SIZE];
    logic [robPkg::PHYS_W-1:0]  entOldPhys [robPkg::ROB_SIZE];
    logic                       entHasDst  [robPkg::ROB_SIZE];

    // entry state
    logic [robPkg::ROB_SIZE-1:0]    entValid;
    logic [robPkg::ROB_SIZE-1:0]    entDone;

    logic [robPkg::TAG_W-1:0]       head;           // oldest entry
    logic [robPkg::TAG_W-1:0]       tail;           // next free slot
    logic [robPkg::ROB_CNT_W-1:0]   count;
    logic [robPkg::ROB_CNT_W-1:0]   countPending;
    logic                           retireNow;

    // ------------------------------------------------------
    // status toward rename
    // ------------------------------------------------------
    // the entry sitting in the rename register counts as taken
    assign countPending = count + {{(robPkg::ROB_CNT_W-1){1'b0}}, allocValid};
    assign robFull      = countPending >= robPkg::ROB_CNT_W'(robPkg::ROB_SIZE);
    assign nextTag      = allocValid ? tail + 1'b1 : tail;

    assign retireNow = entValid[head] && entDone[head];

    // ------------------------------------------------------
    // queue control
    // ------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            entValid    <= '0;
            entDone     <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            retireValid <= 1'b0;
        end else begin
            if (allocValid) begin
                entValid[tail] <= 1'b1;
                entDone[tail]  <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (completeValid) begin
                entDone[completeTag] <= 1'b1;
            end
            // a completing tag is never the head that retires now
            if (retireNow) begin
                entValid[head] <= 1'b0;
                entDone[head]  <= 1'b0;
                head <= head + 1'b1;
            end
            retireValid <= retireNow;
            case ({allocValid, retireNow})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------
    // payload write and retire fields
    // ------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (allocValid) begin
            entPc[tail]      <= allocPc;
            entArch[tail]    <= allocArch;
            entPhys[tail]    <= allocPhys;
            entOldPhys[tail] <= allocOldPhys;
            entHasDst[tail]  <= allocHasDst;
        end
        if (retireNow) begin
            retirePc      <= entPc[head];
            retireArch    <= entArch[head];
            retirePhys    <= entPhys[head];
            retireOldPhys <= entOldPhys[head];
            retireHasDst  <= entHasDst[head];
        end
    end

    // rename must have held back on robFull
    allocNoOverflow: assert property (@(posedge CLK) disable iff (!RESET)
        allocValid |-> count < robPkg::ROB_CNT_W'(robPkg::ROB_SIZE));

    // completions only for live entries, and only once
    completeLive: assert property (@(posedge CLK) disable iff (!RESET)
        completeValid |-> entValid[completeTag] && !entDone[completeTag]);

endmodule

`default_nettype wire

// File: hw/renameStage.sv
// ----------------------------------------------------------
// rename stage
// speculative map table, physical free list, alloc register
// ----------------------------------------------------------
`default_nettype none

module renameStage (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         dispatchValid,
    input  wire  [robPkg::PC_W-1:0]     dispatchPc,
    input  wire  [robPkg::ARCH_W-1:0]   dispatchArch,
    input  wire                         hasDst,
    input  wire                         robFull,
    input  wire  [robPkg::TAG_W-1:0]    nextTag,
    input  wire                         freeValid,
    input  wire  [robPkg::PHYS_W-1:0]   freePhys,
    output logic                        dispatchReady,
    output logic [robPkg::TAG_W-1:0]    dispatchTag,
    output logic [robPkg::PHYS_W-1:0]   dispatchPhys,
    output logic                        allocValid,
    output logic [robPkg::PC_W-1:0]     allocPc,
    output logic [robPkg::ARCH_W-1:0]   allocArch,
    output logic [robPkg::PHYS_W-1:0]   allocPhys,
    output logic [robPkg::PHYS_W-1:0]   allocOldPhys,
    output logic                        allocHasDst
);

    logic [robPkg::PHYS_W-1:0]      specMap  [robPkg::ARCH_REGS];
    logic [robPkg::PHYS_W-1:0]      freeList [robPkg::FREE_REGS];
    logic [robPkg::FREE_W-1:0]      freeHead;       // next register handed out
    logic [robPkg::FREE_W-1:0]      freeTail;       // where returned registers go
    logic [robPkg::FREE_CNT_W-1:0]  freeCount;
    logic                           accept;
    logic                           popFree;
    logic [robPkg::PHYS_W-1:0]      oldPhys;

    // ------------------------------------------------------
    // dispatch side
    // ------------------------------------------------------
    assign dispatchReady = (freeCount != '0) && !robFull;
    assign accept        = dispatchValid && dispatchReady;
    assign popFree       = accept && hasDst;    // no destination, no register taken

    assign dispatchTag  = nextTag;
    assign dispatchPhys = hasDst ? freeList[freeHead] : '0;
    assign oldPhys      = hasDst ? specMap[dispatchArch] : '0;

    // speculative map, identity after reset
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < robPkg::ARCH_REGS; i++) begin
                specMap[i] <= robPkg::PHYS_W'(i);
            end
        end else if (popFree) begin
            specMap[dispatchArch] <= dispatchPhys;
        end
    end

    // ------------------------------------------------------
    // free list FIFO
    // ------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < robPkg::FREE_REGS; i++) begin
                freeList[i] <= robPkg::PHYS_W'(robPkg::FREE_BASE + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= robPkg::FREE_CNT_W'(robPkg::FREE_REGS);
        end else begin
            if (freeValid) begin
                freeList[freeTail] <= freePhys;
                freeTail <= freeTail + 1'b1;
            end
            if (popFree) begin
                freeHead <= freeHead + 1'b1;
            end
            case ({freeValid, popFree})
                2'b10:   freeCount <= freeCount + 1'b1;
                2'b01:   freeCount <= freeCount - 1'b1;
                default: freeCount <= freeCount;    // both or neither
            endcase
        end
    end

    // ------------------------------------------------------
    // registered entry toward the ROB
    // ------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            allocValid <= 1'b0;
        end else begin
            allocValid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            allocPc      <= dispatchPc;
            allocArch    <= dispatchArch;
            allocPhys    <= dispatchPhys;
            allocOldPhys <= oldPhys;
            allocHasDst  <= hasDst;
        end
    end

    // the RAT only returns registers that are out of the list
    freeCountBound: assert property (@(posedge CLK) disable iff (!RESET)
        freeCount <= robPkg::FREE_CNT_W'(robPkg::FREE_REGS));
    freeNoOverflow: assert property (@(posedge CLK) disable iff (!RESET)
        freeValid |-> freeCount < robPkg::FREE_CNT_W'(robPkg::FREE_REGS));

endmodule

`default_nettype wire

// File: hw/robPkg.sv
// ----------------------------------------------------------
// robPkg
// sizes, index widths and reset mapping of the ROB core
// ----------------------------------------------------------
`default_nettype none

package robPkg;

    // ------------------------------------------------------
    // sizes
    // ------------------------------------------------------
    localparam int ARCH_REGS = 16;                  // architectural registers
    localparam int PHYS_REGS = 32;                  // physical registers
    localparam int ROB_SIZE  = 16;                  // reorder buffer entries
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    // ------------------------------------------------------
    // index widths
    // ------------------------------------------------------
    localparam int ARCH_W = $clog2(ARCH_REGS);      // 4 bits
    localparam int PHYS_W = $clog2(PHYS_REGS);      // 5 bits
    localparam int TAG_W  = $clog2(ROB_SIZE);       // 4 bits
    localparam int PC_W   = 32;

    // free list pointers wrap over FREE_REGS slots
    localparam int FREE_W = $clog2(FREE_REGS);

    // occupancy counters need one extra bit
    // so that a full queue is told apart from an empty one
    localparam int FREE_CNT_W = FREE_W + 1;
    localparam int ROB_CNT_W  = TAG_W + 1;

    // ------------------------------------------------------
    // reset mapping
    // ------------------------------------------------------
    // arch reg i starts on phys reg i in both map tables
    // free list then holds FREE_BASE up to PHYS_REGS-1, ascending
    localparam int FREE_BASE = ARCH_REGS;

endpackage

`default_nettype wire
